/* src/pad_cfg_pkg.sv */
// configuration constants of the zero-padding filter
// datapath count, kernel limits and derived field widths

package pad_cfg_pkg;

    // parallel datapaths handled each beat
    localparam int MEMBERS = 8;

    // largest odd kernel width, any smaller odd kernel is allowed
    localparam int KERNEL_W_MAX = 7;

    localparam int KW2_MAX = KERNEL_W_MAX / 2; // 7 -> 3, 5 -> 2, 3 -> 1

    // kernel_w_1 field and clr code share this width
    localparam int BITS_KERNEL_W = 3;

    // half kernel width, kernel_w_1 with its lsb dropped
    localparam int BITS_KW2 = BITS_KERNEL_W - 1;

endpackage

/* src/pad_types_pkg.sv */
// packed structs of the zero-padding filter
// side-band word, column tracker state, registered result

package pad_types_pkg;

    import pad_cfg_pkg::*;

    // side-band word of one datapath for one beat
    typedef struct packed {
        logic                     is_config;    // config beat, full mask forced open
        logic                     is_cin_last;  // last input channel, column may step
        logic                     is_cols_1_k2; // high at column (cols-1-kw/2)
        logic [BITS_KERNEL_W-1:0] kernel_w_1;   // kernel width minus one
    } tuser_t;

    // column tracker state, all vectors indexed from 1 up to KW2_MAX
    typedef struct packed {
        logic [KW2_MAX:1] col_start;      // one-hot walk over the first kw/2 columns
        logic [KW2_MAX:1] col_end;        // one-hot walk towards the last column
        logic [KW2_MAX:1] col_end_masked; // col_end seen by the datapath before last full
    } col_state_t;

    // registered result of one datapath
    typedef struct packed {
        logic                     valid_full;    // full sum passes
        logic                     valid_partial; // partial sum passes
        logic [BITS_KERNEL_W-1:0] clr;           // 0 centre, odd left, even right
    } pad_out_t;

endpackage

/* src/pad_col_tracker.sv */
// column position tracker of the padding filter
// per datapath start, end and masked end shift registers

`timescale 1ns/10ps

module pad_col_tracker
    import pad_cfg_pkg::*, pad_types_pkg::*;
(
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               aclken,
    input  logic [MEMBERS-1:0] valid_in,
    input  tuser_t             user_in   [MEMBERS-1:0],
    output col_state_t         col_state [MEMBERS-1:0]
);

    for (genvar m = 0; m < MEMBERS; m++) begin : g_dp
        logic [BITS_KW2-1:0] kw2;          // kernel width / 2, used as lut select
        logic                step;         // column step of this datapath
        logic [KW2_MAX:0]    col_end_ext;  // col_end with a constant zero at index 0
        logic [KW2_MAX:1]    col_end_in;
        logic [KW2_MAX:1]    col_start_in;
        logic [KW2_MAX:0]    next_full_lut; // datapath sits just before the last full one
        col_state_t          state_q;

        assign kw2  = user_in[m].kernel_w_1[BITS_KERNEL_W-1:1];
        assign step = aclken && valid_in[m] && user_in[m].is_cin_last;

        assign col_end_ext  = {state_q.col_end, 1'b0}; // kw2 = 0 picks the zero
        assign col_end_in   = {state_q.col_end[KW2_MAX-1:1], user_in[m].is_cols_1_k2};
        assign col_start_in = {state_q.col_start[KW2_MAX-1:1], col_end_ext[kw2]}; // mux on kw2

        assign next_full_lut[0] = 1'b1; // kernel of 1, every datapath is full
        for (genvar k = 1; k <= KW2_MAX; k++) begin : g_kw
            localparam int KW = 2 * k + 1;
            assign next_full_lut[k] = (m % KW) == KW - 2;
        end

        always_ff @(posedge aclk or negedge rst_n) begin
            if (!rst_n) begin
                state_q.col_start      <= KW2_MAX'(1); // first column pending
                state_q.col_end        <= '0;
                state_q.col_end_masked <= '0;
            end else if (step) begin
                state_q.col_end   <= col_end_in;
                state_q.col_start <= col_start_in;
                if (next_full_lut[kw2]) begin
                    state_q.col_end_masked <= col_end_in; // same shift, narrower enable
                end
            end
        end

        assign col_state[m] = state_q;
    end

endmodule

/* src/pad_mask_lut.sv */
// full and partial mask lookups of the padding filter
// one lut entry per odd kernel per datapath, selected by kw/2

`timescale 1ns/10ps

module pad_mask_lut
    import pad_cfg_pkg::*, pad_types_pkg::*;
(
    input  tuser_t             user_in   [MEMBERS-1:0],
    input  col_state_t         col_state [MEMBERS-1:0],
    output logic [MEMBERS-1:0] mask_full,
    output logic [MEMBERS-1:0] mask_partial
);

    for (genvar m = 0; m < MEMBERS; m++) begin : g_dp
        logic [BITS_KW2-1:0] kw2;         // lut select, 0 for a kernel of 1
        logic [KW2_MAX:0]    col_end_ext; // zero at index 0 keeps the triangle rows in range
        logic [KW2_MAX:0]    allow_full;

        assign kw2         = user_in[m].kernel_w_1[BITS_KERNEL_W-1:1];
        assign col_end_ext = {col_state[m].col_end, 1'b0};

        // kernel of 1 never pads
        assign allow_full[0] = 1'b1;

        for (genvar k = 1; k <= KW2_MAX; k++) begin : g_full_kw
            localparam int KW        = 2 * k + 1;
            localparam bit FULL_DP   = (m % KW) == KW - 1;         // last of its kernel group
            localparam bit UNUSED    = m >= (MEMBERS / KW) * KW;   // past the last whole group
            localparam bit MALFORMED = (m % KW) < k;               // wraps into the next row
            logic start_cols;

            assign start_cols = |col_state[m].col_start[k:1]; // first kw/2 columns

            // start and middle columns pass only full datapaths,
            // the last column passes the padded partial groups too
            assign allow_full[k] = (FULL_DP && !start_cols)
                                || (col_end_ext[k] && !MALFORMED && !UNUSED);
        end

        assign mask_full[m] = allow_full[kw2] | user_in[m].is_config; // config beats pass

        if (m == 0) begin : g_no_partial
            assign mask_partial[0] = 1'b0; // datapath 0 has no partial sum
        end else begin : g_partial
            logic [KW2_MAX:0] stop_partial;

            assign stop_partial[0] = 1'b1; // kernel of 1 has no partials

            for (genvar k = 1; k <= KW2_MAX; k++) begin : g_part_kw
                localparam int KW     = 2 * k + 1;
                localparam int LO     = m % KW;
                localparam bit UNUSED = m >= (MEMBERS / KW) * KW;
                logic end_partial;

                if (LO > k) begin : g_last_only
                    // partials here are only wrong on the last column
                    assign end_partial = col_end_ext[k];
                end else begin : g_triangle
                    // one row of the blocking triangle, bits LO..k
                    assign end_partial = |col_end_ext[k:LO];
                end

                assign stop_partial[k] = end_partial || UNUSED;
            end

            assign mask_partial[m] = !stop_partial[kw2];
        end
    end

endmodule

/* src/pad_clr_encoder.sv */
// centre/left/right code of the padding filter
// registered left code from col_start, right code from col_end_masked

`timescale 1ns/10ps

module pad_clr_encoder
    import pad_cfg_pkg::*, pad_types_pkg::*;
(
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic                     aclken,
    input  logic [MEMBERS-1:0]       valid_in,
    input  tuser_t                   user_in   [MEMBERS-1:0],
    input  col_state_t               col_state [MEMBERS-1:0],
    output logic [BITS_KERNEL_W-1:0] clr_code  [MEMBERS-1:0]
);

    for (genvar m = 0; m < MEMBERS; m++) begin : g_dp
        logic                     step;
        logic [BITS_KERNEL_W-1:0] left_next;
        logic [BITS_KERNEL_W-1:0] left_q;
        logic [BITS_KERNEL_W-1:0] right;

        assign step = aclken && valid_in[m] && user_in[m].is_cin_last;

        // left = 1 + 2*(j-1) + kw - KERNEL_W_MAX for col_start bit j,
        // with kw = kernel_w_1 + 1 this folds to 2*j + kernel_w_1 - KERNEL_W_MAX
        always_comb begin
            left_next = '0; // empty col_start, centre
            for (int j = 1; j <= KW2_MAX; j++) begin
                if (col_state[m].col_start[j]) begin
                    left_next = BITS_KERNEL_W'(2 * j) + user_in[m].kernel_w_1
                              - BITS_KERNEL_W'(KERNEL_W_MAX); // wraps mod 2^BITS_KERNEL_W
                end
            end
        end

        always_ff @(posedge aclk or negedge rst_n) begin
            if (!rst_n) begin
                left_q <= BITS_KERNEL_W'(1); // first column is left of centre
            end else if (step) begin
                left_q <= left_next;
            end
        end

        // right = 2*j for col_end_masked bit j, 0 when empty
        always_comb begin
            right = '0;
            for (int j = 1; j <= KW2_MAX; j++) begin
                if (col_state[m].col_end_masked[j]) begin
                    right = BITS_KERNEL_W'(2 * j);
                end
            end
        end

        assign clr_code[m] = left_q | right;
    end

endmodule

/* src/pad_out_stage.sv */
// output register of the padding filter
// gates valids with both masks and registers them with the clr code

`timescale 1ns/10ps

module pad_out_stage
    import pad_cfg_pkg::*, pad_types_pkg::*;
(
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic                     aclken,
    input  logic [MEMBERS-1:0]       valid_in,
    input  logic [MEMBERS-1:0]       mask_full,
    input  logic [MEMBERS-1:0]       mask_partial,
    input  logic [BITS_KERNEL_W-1:0] clr_code [MEMBERS-1:0],
    output pad_out_t                 res_out  [MEMBERS-1:0]
);

    // joins the mask and clr branches, fixed one cycle latency
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int m = 0; m < MEMBERS; m++) begin
                res_out[m] <= '0;
            end
        end else if (aclken) begin // stall holds every result
            for (int m = 0; m < MEMBERS; m++) begin
                res_out[m].valid_full    <= valid_in[m] & mask_full[m];
                res_out[m].valid_partial <= valid_in[m] & mask_partial[m];
                res_out[m].clr           <= clr_code[m];
            end
        end
    end

endmodule

/* src/pad_filter_top.sv */
// top level of the horizontal zero-padding filter
// column tracker feeding mask lookup and clr encoder, then output stage

`timescale 1ns/10ps

module pad_filter_top
    import pad_cfg_pkg::*, pad_types_pkg::*;
(
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               aclken,    // global stall, low freezes all state
    input  logic [MEMBERS-1:0] valid_in,
    input  tuser_t             user_in [MEMBERS-1:0],
    output pad_out_t           res_out [MEMBERS-1:0]
);

    col_state_t               col_state [MEMBERS-1:0];
    logic [MEMBERS-1:0]       mask_full;
    logic [MEMBERS-1:0]       mask_partial;
    logic [BITS_KERNEL_W-1:0] clr_code  [MEMBERS-1:0];

    pad_col_tracker tracker_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .aclken    (aclken),
        .valid_in  (valid_in),
        .user_in   (user_in),
        .col_state (col_state)
    );

    pad_mask_lut mask_lut_inst (
        .user_in      (user_in),
        .col_state    (col_state),
        .mask_full    (mask_full),
        .mask_partial (mask_partial)
    );

    pad_clr_encoder clr_encoder_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .aclken    (aclken),
        .valid_in  (valid_in),
        .user_in   (user_in),
        .col_state (col_state),
        .clr_code  (clr_code)
    );

    pad_out_stage out_stage_inst (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .aclken       (aclken),
        .valid_in     (valid_in),
        .mask_full    (mask_full),
        .mask_partial (mask_partial),
        .clr_code     (clr_code),
        .res_out      (res_out)
    );

endmodule

/* verif/tb_clk_gen.sv */
// testbench clock and reset source
// 20 ns clock, active low reset held for 3 cycles

`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1; // released just after the third edge
    end

endmodule

/* verif/pad_filter_asserts.sv */
// concurrent assertions on the padding filter top level
// valid gating, datapath 0 partial, stall hold

`timescale 1ns/10ps

module pad_filter_asserts
    import pad_cfg_pkg::*, pad_types_pkg::*;
(
    input logic               aclk,
    input logic               rst_n,
    input logic               aclken,
    input logic [MEMBERS-1:0] valid_in,
    input pad_out_t           res_out [MEMBERS-1:0]
);

    for (genvar m = 0; m < MEMBERS; m++) begin : g_dp
        // no valid out of an idle input beat
        a_gated: assert property (@(posedge aclk) disable iff (!rst_n)
            aclken && !valid_in[m] |=> !res_out[m].valid_full && !res_out[m].valid_partial)
            else $error("valid out without valid in, datapath %0d", m);

        // stall keeps every result
        a_hold: assert property (@(posedge aclk) disable iff (!rst_n)
            !aclken |=> $stable(res_out[m]))
            else $error("result changed during stall, datapath %0d", m);
    end

    a_no_partial0: assert property (@(posedge aclk) disable iff (!rst_n)
        !res_out[0].valid_partial)
        else $error("datapath 0 reported a partial sum");

endmodule

/* verif/pad_filter_tb.sv */
// testbench of the padding filter top level
// reads beats from the stimulus file, drives the DUT, checks results, watchdog

`timescale 1ns/10ps

module pad_filter_tb
    import pad_cfg_pkg::*, pad_types_pkg::*;
();

    localparam int MAX_LINES = 64;

    logic               aclk;
    logic               rst_n;
    logic               aclken;
    logic [MEMBERS-1:0] valid_in;
    tuser_t             user_in [MEMBERS-1:0];
    pad_out_t           res_out [MEMBERS-1:0];

    logic [7:0]         en_mem    [0:MAX_LINES-1];
    logic [7:0]         valid_mem [0:MAX_LINES-1];
    logic [7:0]         user_mem  [0:MAX_LINES-1][0:MEMBERS-1];
    logic [7:0]         vf_mem    [0:MAX_LINES-1];
    logic [7:0]         vp_mem    [0:MAX_LINES-1];
    logic [7:0]         clr_mem   [0:MAX_LINES-1][0:MEMBERS-1];
    int                 n_lines = 0;

    tb_clk_gen clk_gen_inst (.clk(aclk), .rst_n(rst_n));

    pad_filter_top pad_filter_top_inst (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .aclken   (aclken),
        .valid_in (valid_in),
        .user_in  (user_in),
        .res_out  (res_out)
    );

    bind pad_filter_top pad_filter_asserts pad_filter_asserts_inst (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .aclken   (aclken),
        .valid_in (valid_in),
        .res_out  (res_out)
    );

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_valids(input string what, input logic [MEMBERS-1:0] got,
                                  input logic [MEMBERS-1:0] exp);
        int bad;
        bad = -1;
        for (int m = MEMBERS - 1; m >= 0; m--) begin
            if (got[m] !== exp[m]) bad = m; // report lowest failing datapath
        end
        if (bad >= 0) begin
            $display("Mismatch at %0t: %s datapath %0d got %b expected %b",
                     $time, what, bad, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_clr(input int m, input pad_out_t got, input pad_out_t exp);
        if (got.clr !== exp.clr) begin
            $display("Mismatch at %0t: clr datapath %0d got %0d expected %0d",
                     $time, m, got.clr, exp.clr);
            stop_on_error();
        end
    endtask

    task automatic read_stim();
        int    fd;
        int    cnt;
        string line;
        logic [7:0] f [0:19];
        fd = $fopen("verif/pad_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file verif/pad_stim.txt");
            stop_on_error();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 4 || line.getc(0) == 8'h23) continue; // comment or blank
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                          f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
            if (cnt != 20 || n_lines >= MAX_LINES) begin
                $display("Stimulus line %0d is malformed or the file is too long", n_lines);
                stop_on_error();
            end
            en_mem[n_lines]    = f[0];
            valid_mem[n_lines] = f[1];
            for (int m = 0; m < MEMBERS; m++) begin
                user_mem[n_lines][m] = f[2 + m];
                clr_mem[n_lines][m]  = f[12 + m];
            end
            vf_mem[n_lines] = f[10];
            vp_mem[n_lines] = f[11];
            n_lines++;
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("The stimulus file holds no beats");
            stop_on_error();
        end
    endtask

    task automatic check_results(input int i);
        logic [MEMBERS-1:0] got_vf;
        logic [MEMBERS-1:0] got_vp;
        pad_out_t           exp;
        for (int m = 0; m < MEMBERS; m++) begin
            got_vf[m] = res_out[m].valid_full;
            got_vp[m] = res_out[m].valid_partial;
        end
        compare_valids("valid_full", got_vf, i < 0 ? '0 : vf_mem[i]);
        compare_valids("valid_partial", got_vp, i < 0 ? '0 : vp_mem[i]);
        for (int m = 0; m < MEMBERS; m++) begin
            exp.valid_full    = i < 0 ? 1'b0 : vf_mem[i][m];
            exp.valid_partial = i < 0 ? 1'b0 : vp_mem[i][m];
            exp.clr           = i < 0 ? '0 : clr_mem[i][m][BITS_KERNEL_W-1:0];
            compare_clr(m, res_out[m], exp);
        end
    endtask

    // watchdog sized from the stimulus length plus reset and margin
    initial begin
        wait (n_lines > 0);
        #((n_lines + 10) * 20);
        $display("Watchdog expired before the stimulus finished");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin
        aclken   = 1'b0;
        valid_in = '0;
        for (int m = 0; m < MEMBERS; m++) user_in[m] = '0;
        read_stim();
        wait (rst_n === 1'b1);
        check_results(-1); // reset state, all results cleared
        @(posedge aclk);
        #2;
        for (int i = 0; i < n_lines; i++) begin
            aclken   = en_mem[i][0];
            valid_in = valid_mem[i];
            for (int m = 0; m < MEMBERS; m++) user_in[m] = tuser_t'(user_mem[i][m][5:0]);
            @(posedge aclk);
            #1 check_results(i); // settled after the edge
            #1;
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* verif/pad_stim.txt */
# en valid user0..user7 (cfg,cin_last,cols_1_k2,kernel_w_1[2:0]) | exp_vf exp_vp exp_clr0..7
# all hex, expected values are res_out after the edge that takes this beat
1 ff 00 00 00 00 00 00 00 00 ff 00 1 1 1 1 1 1 1 1
1 ff 14 14 14 14 14 14 14 14 00 1e 1 1 1 1 1 1 1 1
1 ff 14 14 14 14 14 14 14 14 00 1e 7 7 7 7 7 7 7 7
1 ff 14 14 14 14 14 14 14 14 10 1e 1 1 1 1 1 1 1 1
1 ff 14 14 14 14 14 14 14 14 10 1e 3 3 3 3 3 3 3 3
1 ff 14 14 14 14 14 14 14 14 10 1e 0 0 0 0 0 0 0 0
1 ff 1c 1c 1c 1c 1c 1c 1c 1c 10 1e 0 0 0 0 0 0 0 0
1 ff 14 14 14 14 14 14 14 14 10 1c 0 0 0 2 0 0 0 0
1 ff 14 14 14 14 14 14 14 14 1c 00 0 0 0 4 0 0 0 0
1 ff 14 14 14 14 14 14 14 14 00 1e 0 0 0 6 0 0 0 0
0 ff 14 14 14 14 14 14 14 14 00 1e 0 0 0 6 0 0 0 0
1 ff 14 14 14 14 14 14 14 14 00 1e 7 7 7 7 7 7 7 7
0 ff 14 14 14 14 14 14 14 14 00 1e 7 7 7 7 7 7 7 7
1 ff 14 14 14 14 14 14 14 14 10 1e 1 1 1 1 1 1 1 1
1 ff 24 24 24 24 24 24 24 24 ff 1e 3 3 3 3 3 3 3 3
1 ff 14 14 14 14 14 14 14 14 10 1e 3 3 3 3 3 3 3 3
1 0f 14 14 14 14 14 14 14 14 00 0e 0 0 0 0 0 0 0 0
1 ff 1a 1e 18 1c 1a 1e 1c 1a 04 3a 0 0 0 0 0 0 0 0
1 ff 12 16 10 14 12 16 14 12 14 28 0 0 2 2 2 2 0 2
1 ff 16 16 16 16 16 16 16 16 40 78 0 0 4 4 4 4 0 4
1 ff 12 12 12 12 12 12 12 12 24 3e 1 0 4 4 5 6 0 5
0 ff 10 10 10 10 10 10 10 10 24 3e 1 0 4 4 5 6 0 5
1 00 14 14 14 14 14 14 14 14 00 00 7 0 4 4 7 6 0 7
1 ff 10 10 10 10 10 10 10 10 ff 00 7 0 4 4 7 6 0 7
1 ff 10 10 10 10 10 10 10 10 ff 00 7 0 0 0 7 0 0 7
1 ff 10 10 10 10 10 10 10 10 ff 00 0 0 0 0 0 0 0 0

/* files.f */
src/pad_cfg_pkg.sv
src/pad_types_pkg.sv
src/pad_col_tracker.sv
src/pad_mask_lut.sv
src/pad_clr_encoder.sv
src/pad_out_stage.sv
src/pad_filter_top.sv
verif/tb_clk_gen.sv
verif/pad_filter_asserts.sv
verif/pad_filter_tb.sv

/* Makefile */
# Verilator build and run of the padding filter testbench

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
TOP        ?= pad_filter_tb
RTL_TOP    ?= pad_filter_top
FILE_LIST  ?= files.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
